/* src/serial_mem_pkg.sv */
package serial_mem_pkg;

	// command field widths
	localparam int addr_bits = 32;
	localparam int len_bits = 24;

	// 4 KB of on-chip storage, addresses above alias into it
	localparam int mem_addr_bits = 12;
	localparam int mem_latency = 3;
	localparam int lat_cnt_bits = $clog2(mem_latency + 1);

	// uart bit time
	localparam int clks_per_bit = 8;
	localparam int clk_cnt_bits = $clog2(clks_per_bit);

	// frame and reply characters
	localparam logic [7:0] char_hdr = "!";
	localparam logic [7:0] char_rd = "R";
	localparam logic [7:0] char_wr = "W";
	localparam logic [7:0] char_version = "V";
	localparam logic [7:0] char_bad_cmd = "?";
	localparam logic [7:0] char_no_frame = "!";
	localparam logic [7:0] char_overrun = "%";
	localparam logic [7:0] char_wr_done = "w";
	localparam logic [7:0] char_version_digit = "1";

	localparam int version_len = 8;

	typedef enum logic [3:0] {
		mode_wait,
		mode_cmd,
		mode_len2,
		mode_len1,
		mode_len0,
		mode_addr3,
		mode_addr2,
		mode_addr1,
		mode_addr0,
		mode_read,
		mode_write,
		mode_version,
		mode_invalid
	} parse_mode_t;

	// request held by the parser until the memory acks
	typedef struct packed {
		logic [addr_bits-1:0] addr;
		logic [15:0] wr_data;
		logic [1:0] wr_mask;
		logic we;
		logic enable;
	} mem_req_t;

endpackage

/* src/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
	input  logic clk,
	input  logic reset,
	input  logic rxd,
	output logic [7:0] rx_data,
	output logic rx_strobe
);
	import serial_mem_pkg::*;

	logic rxd_meta;
	logic rxd_sync;
	logic rxd_prev;
	logic busy;
	// 0 is the start bit, 1..8 data, 9 stop
	logic [3:0] bit_idx;
	logic [clk_cnt_bits-1:0] clk_cnt;
	logic sample_data;

	assign sample_data = busy && (clk_cnt == '0) && (bit_idx >= 4'd1) && (bit_idx <= 4'd8);

	always_ff @(posedge clk) begin
		rx_strobe <= 1'b0;
		if (reset) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
			busy <= 1'b0;
			bit_idx <= 4'd0;
			clk_cnt <= '0;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
			if (!busy) begin
				// falling edge opens a start bit, first sample half a bit later
				if (rxd_prev && !rxd_sync) begin
					busy <= 1'b1;
					bit_idx <= 4'd0;
					clk_cnt <= clk_cnt_bits'(clks_per_bit / 2 - 1);
				end
			end else if (clk_cnt != '0) begin
				clk_cnt <= clk_cnt - 1'b1;
			end else begin
				clk_cnt <= clk_cnt_bits'(clks_per_bit - 1);
				bit_idx <= bit_idx + 4'd1;
				if (bit_idx == 4'd0) begin
					// glitch, line went back high before mid start bit
					if (rxd_sync)
						busy <= 1'b0;
				end else if (bit_idx == 4'd9) begin
					busy <= 1'b0;
					rx_strobe <= 1'b1;
				end
			end
		end
	end

	// lsb arrives first
	always_ff @(posedge clk) begin
		if (sample_data)
			rx_data <= {rxd_sync, rx_data[7:1]};
	end

endmodule

/* src/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
	input  logic clk,
	input  logic reset,
	input  logic [7:0] tx_data,
	input  logic tx_strobe,
	output logic txd,
	output logic tx_ready
);
	import serial_mem_pkg::*;

	// stop, data lsb first, start; ones shift in behind the frame
	logic [9:0] shift;
	logic [3:0] bits_left;
	logic [clk_cnt_bits-1:0] clk_cnt;

	assign tx_ready = (bits_left == 4'd0);
	assign txd = shift[0];

	always_ff @(posedge clk) begin
		if (reset) begin
			shift <= '1;
			bits_left <= 4'd0;
			clk_cnt <= '0;
		end else if (tx_ready) begin
			if (tx_strobe) begin
				shift <= {1'b1, tx_data, 1'b0};
				bits_left <= 4'd10;
				clk_cnt <= clk_cnt_bits'(clks_per_bit - 1);
			end
		end else if (clk_cnt != '0) begin
			clk_cnt <= clk_cnt - 1'b1;
		end else begin
			// end of one bit time
			shift <= {1'b1, shift[9:1]};
			bits_left <= bits_left - 4'd1;
			clk_cnt <= clk_cnt_bits'(clks_per_bit - 1);
		end
	end

endmodule

/* src/user_command_parser.sv */
`timescale 1ns/1ps

module user_command_parser (
	input  logic clk,
	input  logic reset,
	input  logic [7:0] rx_data,
	input  logic rx_strobe,
	output logic [7:0] tx_data,
	output logic tx_strobe,
	input  logic tx_ready,
	output serial_mem_pkg::mem_req_t mem_req,
	input  logic [15:0] rd_data,
	input  logic ack,
	input  logic idle
);
	import serial_mem_pkg::*;

	parse_mode_t mode;
	logic is_read;
	logic rd_pending;
	logic wr_pending;
	logic [len_bits-1:0] count;
	logic tx_free;

	// ready only drops a cycle after the strobe, so a strobe in flight counts as busy
	assign tx_free = tx_ready && !tx_strobe;

	always_ff @(posedge clk) begin
		tx_strobe <= 1'b0;
		if (reset) begin
			mode <= mode_wait;
			is_read <= 1'b0;
			rd_pending <= 1'b0;
			wr_pending <= 1'b0;
			count <= '0;
			mem_req.enable <= 1'b0;
			mem_req.we <= 1'b0;
		end else begin
			case (mode)
			mode_wait: begin
				if (rx_strobe) begin
					if (rx_data == char_hdr) begin
						mode <= mode_cmd;
					end else begin
						tx_data <= char_no_frame;
						tx_strobe <= 1'b1;
					end
				end
			end
			mode_cmd: begin
				if (rx_strobe) begin
					case (rx_data)
					char_rd: begin
						is_read <= 1'b1;
						mode <= mode_len2;
					end
					char_wr: begin
						is_read <= 1'b0;
						mode <= mode_len2;
					end
					char_version: begin
						count <= len_bits'(version_len);
						mode <= mode_version;
					end
					default: mode <= mode_invalid;
					endcase
				end
			end
			// byte count, big endian
			mode_len2: begin
				if (rx_strobe) begin
					count[23:16] <= rx_data;
					mode <= mode_len1;
				end
			end
			mode_len1: begin
				if (rx_strobe) begin
					count[15:8] <= rx_data;
					mode <= mode_len0;
				end
			end
			mode_len0: begin
				if (rx_strobe) begin
					count[7:0] <= rx_data;
					mode <= mode_addr3;
				end
			end
			// start address, big endian
			mode_addr3: begin
				if (rx_strobe) begin
					mem_req.addr[31:24] <= rx_data;
					mode <= mode_addr2;
				end
			end
			mode_addr2: begin
				if (rx_strobe) begin
					mem_req.addr[23:16] <= rx_data;
					mode <= mode_addr1;
				end
			end
			mode_addr1: begin
				if (rx_strobe) begin
					mem_req.addr[15:8] <= rx_data;
					mode <= mode_addr0;
				end
			end
			mode_addr0: begin
				if (rx_strobe) begin
					mem_req.addr[7:0] <= rx_data;
					mode <= is_read ? mode_read : mode_write;
				end
			end
			mode_read: begin
				// incoming bytes are dropped here
				if (rd_pending) begin
					if (ack) begin
						mem_req.enable <= 1'b0;
						tx_data <= mem_req.addr[0] ? rd_data[15:8] : rd_data[7:0];
						tx_strobe <= 1'b1;
						mem_req.addr <= mem_req.addr + 1'b1;
						count <= count - 1'b1;
						rd_pending <= 1'b0;
					end
				end else if (count == '0) begin
					mode <= mode_wait;
				end else if (tx_free && idle) begin
					mem_req.we <= 1'b0;
					mem_req.enable <= 1'b1;
					rd_pending <= 1'b1;
				end
			end
			mode_write: begin
				if (wr_pending) begin
					if (ack) begin
						mem_req.enable <= 1'b0;
						mem_req.we <= 1'b0;
						mem_req.addr <= mem_req.addr + 1'b1;
						count <= count - 1'b1;
						wr_pending <= 1'b0;
					end
					// previous byte still in the memory, this one is lost
					if (rx_strobe) begin
						tx_data <= char_overrun;
						tx_strobe <= 1'b1;
					end
				end else if (count == '0) begin
					tx_data <= char_wr_done;
					tx_strobe <= 1'b1;
					mode <= mode_wait;
				end else if (rx_strobe) begin
					if (mem_req.addr[0]) begin
						mem_req.wr_data <= {rx_data, 8'h00};
						mem_req.wr_mask <= 2'b10;
					end else begin
						mem_req.wr_data <= {8'h00, rx_data};
						mem_req.wr_mask <= 2'b01;
					end
					mem_req.we <= 1'b1;
					mem_req.enable <= 1'b1;
					wr_pending <= 1'b1;
				end
			end
			mode_version: begin
				if (count == '0) begin
					mode <= mode_wait;
				end else if (tx_free) begin
					tx_data <= char_version_digit;
					tx_strobe <= 1'b1;
					count <= count - 1'b1;
				end
			end
			mode_invalid: begin
				tx_data <= char_bad_cmd;
				tx_strobe <= 1'b1;
				mode <= mode_wait;
			end
			default: mode <= mode_wait;
			endcase
		end
	end

endmodule

/* src/word_memory.sv */
`timescale 1ns/1ps

module word_memory (
	input  logic clk,
	input  logic reset,
	input  serial_mem_pkg::mem_req_t mem_req,
	output logic [15:0] rd_data,
	output logic ack,
	output logic idle
);
	import serial_mem_pkg::*;

	logic [15:0] mem [2**(mem_addr_bits-1)];
	logic [mem_addr_bits-2:0] word_addr;
	logic [lat_cnt_bits-1:0] lat_cnt;
	logic access_done;

	// upper address bits are ignored, so the space aliases
	assign word_addr = mem_req.addr[mem_addr_bits-1:1];

	// last latency cycle, the array is touched on this edge
	assign access_done = !idle && !ack && (lat_cnt == '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			idle <= 1'b1;
			ack <= 1'b0;
			lat_cnt <= '0;
		end else if (idle) begin
			if (mem_req.enable) begin
				idle <= 1'b0;
				lat_cnt <= lat_cnt_bits'(mem_latency - 1);
			end
		end else if (ack) begin
			ack <= 1'b0;
			idle <= 1'b1;
		end else if (lat_cnt == '0) begin
			ack <= 1'b1;
		end else begin
			lat_cnt <= lat_cnt - 1'b1;
		end
	end

	// request is held stable by the parser until ack
	always_ff @(posedge clk) begin
		if (access_done) begin
			if (mem_req.we) begin
				if (mem_req.wr_mask[0])
					mem[word_addr][7:0] <= mem_req.wr_data[7:0];
				if (mem_req.wr_mask[1])
					mem[word_addr][15:8] <= mem_req.wr_data[15:8];
			end else begin
				rd_data <= mem[word_addr];
			end
		end
	end

endmodule

/* src/serial_mem_top.sv */
`timescale 1ns/1ps

module serial_mem_top (
	input  logic clk,
	input  logic reset,
	input  logic rxd,
	output logic txd
);
	import serial_mem_pkg::*;

	logic [7:0] rx_data;
	logic rx_strobe;
	logic [7:0] tx_data;
	logic tx_strobe;
	logic tx_ready;
	mem_req_t mem_req;
	logic [15:0] rd_data;
	logic ack;
	logic idle;

	uart_rx uart_rx_i (
		.clk(clk),
		.reset(reset),
		.rxd(rxd),
		.rx_data(rx_data),
		.rx_strobe(rx_strobe)
	);

	uart_tx uart_tx_i (
		.clk(clk),
		.reset(reset),
		.tx_data(tx_data),
		.tx_strobe(tx_strobe),
		.txd(txd),
		.tx_ready(tx_ready)
	);

	user_command_parser user_command_parser_i (
		.clk(clk),
		.reset(reset),
		.rx_data(rx_data),
		.rx_strobe(rx_strobe),
		.tx_data(tx_data),
		.tx_strobe(tx_strobe),
		.tx_ready(tx_ready),
		.mem_req(mem_req),
		.rd_data(rd_data),
		.ack(ack),
		.idle(idle)
	);

	// stands in for the sdram controller
	word_memory word_memory_i (
		.clk(clk),
		.reset(reset),
		.mem_req(mem_req),
		.rd_data(rd_data),
		.ack(ack),
		.idle(idle)
	);

endmodule

/* verification/serial_mem_checker.sv */
`timescale 1ns/1ps

module serial_mem_checker (
	input  logic clk,
	input  logic reset,
	input  logic txd,
	input  logic exp_push,
	input  logic [7:0] exp_char,
	input  logic [8*12-1:0] exp_test,
	input  logic report,
	input  int model_errors,
	output int pending,
	output int error_total
);
	import serial_mem_pkg::*;

	typedef struct packed {
		logic [8*12-1:0] test;
		logic [7:0] value;
	} expect_t;

	expect_t expected_q[$];
	int pushed = 0;
	int popped = 0;
	int mismatches = 0;
	int unexpected = 0;
	int framing = 0;
	logic reported = 1'b0;

	assign pending = pushed - popped;

	always @(posedge clk) begin
		if (exp_push) begin
			expected_q.push_back('{test: exp_test, value: exp_char});
			pushed = pushed + 1;
		end
	end

	task automatic check_byte(input logic [7:0] value);
		expect_t item;
		if (expected_q.size() == 0) begin
			unexpected++;
			$display("character 0x%02h arrived on txd while no reply was expected", value);
		end else begin
			item = expected_q.pop_front();
			popped++;
			if (item.value !== value) begin
				mismatches++;
				$display("FAILED %0s: expected 0x%02h, actual 0x%02h",
					item.test, item.value, value);
			end
		end
	endtask

	// txd moves on the rising edge, so it is read on the falling one
	initial begin
		logic [7:0] value;
		forever begin
			@(negedge clk);
			if (!reset && txd === 1'b0) begin
				repeat (clks_per_bit / 2 - 1) @(negedge clk);
				if (txd !== 1'b0) begin
					framing++;
					$display("start bit on txd did not last to its middle at %0t", $time);
				end else begin
					for (int i = 0; i < 8; i++) begin
						repeat (clks_per_bit) @(negedge clk);
						value[i] = txd;
					end
					repeat (clks_per_bit) @(negedge clk);
					if (txd !== 1'b1) begin
						framing++;
						$display("stop bit missing on txd at %0t", $time);
					end
					check_byte(value);
				end
			end
		end
	end

	always @(posedge clk) begin
		if (report && !reported) begin
			reported = 1'b1;
			foreach (expected_q[i])
				$display("character 0x%02h for %0s was never received",
					expected_q[i].value, expected_q[i].test);
			error_total = mismatches + unexpected + framing + expected_q.size() + model_errors;
			$display("errors: %0d mismatched, %0d unexpected, %0d framing, %0d missing, %0d model",
				mismatches, unexpected, framing, expected_q.size(), model_errors);
		end
	end

endmodule

/* verification/tb_serial_mem.sv */
`timescale 1ns/1ps

module tb_serial_mem;
	import serial_mem_pkg::*;

	localparam int mem_size = 1 << mem_addr_bits;
	localparam int max_len = 16;
	localparam int wr_rounds = 12;
	localparam int bad_rounds = 4;
	localparam int no_frame_rounds = 4;
	localparam int alias_rounds = 3;
	// header, command, count, address, longest payload and one reply
	localparam int longest_frame = 9 + max_len + 1;
	localparam int frame_count = 1 + 2 * wr_rounds + 2 * bad_rounds + no_frame_rounds + 4
		+ 2 * alias_rounds;
	localparam int watchdog_cycles = 2 * frame_count * longest_frame * 10 * clks_per_bit;

	logic clk;
	logic reset;
	logic rxd;
	logic txd;
	logic exp_push;
	logic [7:0] exp_char;
	logic [8*12-1:0] test_name;
	logic report;
	int pending;
	int error_total;
	int model_errors;

	// what the host has written, aliased to the low address bits
	logic [7:0] model_mem [mem_size];
	logic model_valid [mem_size];
	logic [31:0] span_addr [$];
	int span_len [$];

	serial_mem_top serial_mem_top_i (
		.clk(clk),
		.reset(reset),
		.rxd(rxd),
		.txd(txd)
	);

	serial_mem_checker checker_i (
		.clk(clk),
		.reset(reset),
		.txd(txd),
		.exp_push(exp_push),
		.exp_char(exp_char),
		.exp_test(test_name),
		.report(report),
		.model_errors(model_errors),
		.pending(pending),
		.error_total(error_total)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles with replies still outstanding", watchdog_cycles);
		$display("Done: errors found");
		$finish;
	end

	function automatic int alias_index(input logic [31:0] addr);
		return int'(addr[mem_addr_bits-1:0]);
	endfunction

	// called on a falling edge, returns on one
	task automatic send_byte(input logic [7:0] value);
		logic [9:0] frame;
		frame = {1'b1, value, 1'b0};
		for (int i = 0; i < 10; i++) begin
			rxd = frame[i];
			repeat (clks_per_bit) @(negedge clk);
		end
	endtask

	task automatic expect_reply(input logic [7:0] value);
		exp_char = value;
		exp_push = 1'b1;
		@(negedge clk);
		exp_push = 1'b0;
	endtask

	task automatic wait_replies();
		while (pending != 0)
			@(negedge clk);
		repeat (clks_per_bit) @(negedge clk);
	endtask

	task automatic send_header(input logic [7:0] cmd, input int len, input logic [31:0] addr);
		logic [23:0] count;
		count = 24'(len);
		send_byte(char_hdr);
		send_byte(cmd);
		send_byte(count[23:16]);
		send_byte(count[15:8]);
		send_byte(count[7:0]);
		send_byte(addr[31:24]);
		send_byte(addr[23:16]);
		send_byte(addr[15:8]);
		send_byte(addr[7:0]);
	endtask

	task automatic send_version();
		for (int i = 0; i < version_len; i++)
			expect_reply(char_version_digit);
		send_byte(char_hdr);
		send_byte(char_version);
		wait_replies();
	endtask

	task automatic do_write(input logic [31:0] addr, input int len);
		logic [7:0] data [$];
		int idx;
		for (int i = 0; i < len; i++) begin
			data.push_back(8'($urandom()));
			idx = alias_index(addr + 32'(i));
			model_mem[idx] = data[i];
			model_valid[idx] = 1'b1;
		end
		if (len > 0) begin
			span_addr.push_back(addr);
			span_len.push_back(len);
		end
		expect_reply(char_wr_done);
		send_header(char_wr, len, addr);
		foreach (data[i])
			send_byte(data[i]);
		wait_replies();
	endtask

	task automatic do_read(input logic [31:0] addr, input int len);
		int idx;
		for (int i = 0; i < len; i++) begin
			idx = alias_index(addr + 32'(i));
			if (!model_valid[idx]) begin
				model_errors++;
				$display("read stimulus touches byte 0x%03h that was never written", idx);
			end
			expect_reply(model_mem[idx]);
		end
		send_header(char_rd, len, addr);
		wait_replies();
	endtask

	initial begin
		logic [31:0] addr;
		logic [7:0] value;
		int len;
		int k;
		int off;
		void'($urandom(14029));
		reset = 1'b1;
		rxd = 1'b1;
		exp_push = 1'b0;
		exp_char = 8'h00;
		report = 1'b0;
		model_errors = 0;
		test_name = "reset";
		foreach (model_valid[i])
			model_valid[i] = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		repeat (4) @(negedge clk);

		test_name = "version";
		send_version();

		// full span reads alternate start parity, the others pick an old span
		test_name = "write_read";
		for (int r = 0; r < wr_rounds; r++) begin
			len = 1 + int'($urandom() % max_len);
			addr = $urandom();
			addr[0] = r[1];
			do_write(addr, len);
			if (r % 2 == 0) begin
				do_read(addr, len);
			end else begin
				k = int'($urandom() % span_len.size());
				off = int'($urandom() % span_len[k]);
				len = 1 + int'($urandom() % (span_len[k] - off));
				do_read(span_addr[k] + 32'(off), len);
			end
		end

		test_name = "bad_cmd";
		for (int r = 0; r < bad_rounds; r++) begin
			do
				value = 8'($urandom());
			while (value == char_rd || value == char_wr || value == char_version);
			expect_reply(char_bad_cmd);
			send_byte(char_hdr);
			send_byte(value);
			wait_replies();
			send_version();
		end

		test_name = "no_frame";
		for (int r = 0; r < no_frame_rounds; r++) begin
			do
				value = 8'($urandom());
			while (value == char_hdr);
			expect_reply(char_no_frame);
			send_byte(value);
			wait_replies();
		end

		test_name = "zero_count";
		do_write($urandom(), 0);
		send_version();
		do_read($urandom(), 0);
		send_version();

		test_name = "alias";
		for (int r = 0; r < alias_rounds; r++) begin
			len = 1 + int'($urandom() % max_len);
			addr = $urandom() | 32'(mem_size);
			do_write(addr, len);
			do_read(addr & 32'(mem_size - 1), len);
		end

		@(negedge clk);
		report = 1'b1;
		repeat (2) @(negedge clk);
		if (error_total == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

/* project.f */
src/serial_mem_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/user_command_parser.sv
src/word_memory.sv
src/serial_mem_top.sv
verification/serial_mem_checker.sv
verification/tb_serial_mem.sv

/* Makefile */
# Verilator build and run for the serial memory debug port

VERILATOR ?= verilator
FILELIST ?= project.f
TB_TOP ?= tb_serial_mem
RTL_TOP ?= serial_mem_top
BUILD_DIR ?= obj_dir
LOG ?= sim.log
SIM_FLAGS ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall
PASS_TEXT ?= Done: no errors

RTL_SRCS = $(shell grep '^src/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o sim

# the log decides pass or fail, not the simulator exit code
run: build
	./$(BUILD_DIR)/sim | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
